// File: dv/i3c_monitor_cases.txt
# pattern: 0 HDR exit, 1 target reset, 2 plain START/STOP, 3 HDR exit broken by SCL pulse
# columns: pattern hdr_mode enable sda_falls stall expected (0 none, 1 HDR exit, 2 target reset)
0 1 1 4 0 1
0 0 1 4 0 0
0 1 0 4 0 0
3 1 1 4 0 0
1 0 1 7 0 2
1 0 1 6 0 0
1 0 0 7 0 0
2 0 1 0 0 0
2 1 1 2 0 0
1 1 1 7 0 2
0 1 1 4 0 1
0 1 1 4 1 1
1 0 1 7 1 2
0 1 1 4 1 1
1 0 1 7 1 2
0 1 1 4 1 1
1 0 1 7 1 2
2 0 1 1 0 0
0 1 1 4 0 1

// File: i3c_monitor.f
common/i3c_pkg.sv
src/i3c_line_filter.sv
src/i3c_bus_conditions.sv
i3c_bus_monitor/target_reset_detector.sv
i3c_bus_monitor/i3c_bus_monitor.sv
src/i3c_event_log.sv
src/i3c_monitor_top.sv
dv/i3c_monitor_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -Wno-fatal
TOP       = i3c_monitor_tb
FILELIST  = i3c_monitor.f
BUILD_DIR = obj_dir
BIN       = $(BUILD_DIR)/V$(TOP)
PASS_MSG  = Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/i3c_monitor_tb.sv
/*
  I3C monitor testbench. Replays bus patterns from the case file
  on the raw pins and checks the logged event records
*/
module i3c_monitor_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned LOG_DEPTH   = 4;
  localparam int unsigned HOLD_CYCLES = 16;

  typedef struct packed {
    logic [3:0] pattern;
    logic       hdr_mode;
    logic       enable;
    logic [3:0] falls;
    logic       stall;
    logic [1:0] kind;
  } case_t;

  logic                         clk;
  logic                         rst_n;
  logic                         scl;
  logic                         sda;
  logic                         enable;
  logic                         hdr_mode;
  logic                         evt_ready;
  logic                         evt_valid;
  i3c_pkg::evt_t                evt;
  logic [7:0]                   drop_count;
  case_t                        cases_q[$];
  i3c_pkg::evt_kind_e           exp_q[$];
  int                           n_cases;
  int                           rx_count;
  int                           exp_drops;
  logic [i3c_pkg::TS_WIDTH-1:0] last_ts;
  logic                         hold_ready_low;
  logic [31:0]                  rng_state;

  i3c_monitor_top #(
    .STABLE_CYCLES (4),
    .LOG_DEPTH     (LOG_DEPTH)
  ) i3c_monitor_top_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .scl_i            (scl),
    .sda_i            (sda),
    .enable_i         (enable),
    .is_in_hdr_mode_i (hdr_mode),
    .evt_valid_o      (evt_valid),
    .evt_ready_i      (evt_ready),
    .evt_o            (evt),
    .drop_count_o     (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Each level is held long enough for the stable flags to settle
  task automatic set_lines(input logic scl_v, input logic sda_v);
    @(negedge clk);
    scl = scl_v;
    sda = sda_v;
    repeat (HOLD_CYCLES - 1) @(negedge clk);
  endtask

  // SCL parked low with SDA high, then SDA falls, then STOP
  task automatic hdr_exit_pattern(input int falls, input int pulse_at);
    set_lines(1'b0, 1'b1);
    for (int i = 1; i <= falls; i++) begin
      set_lines(1'b0, 1'b0);
      if (i == pulse_at) begin
        set_lines(1'b1, 1'b0);
        set_lines(1'b0, 1'b0);
      end
      if (i < falls) begin
        set_lines(1'b0, 1'b1);
      end
    end
    set_lines(1'b1, 1'b0);
    set_lines(1'b1, 1'b1);
  endtask

  // START, SDA toggling with SCL low, then repeated START and STOP
  task automatic target_reset_pattern(input int falls);
    set_lines(1'b1, 1'b0);
    set_lines(1'b0, 1'b0);
    for (int i = 0; i < falls; i++) begin
      set_lines(1'b0, 1'b1);
      set_lines(1'b0, 1'b0);
    end
    set_lines(1'b0, 1'b1);
    set_lines(1'b1, 1'b1);
    set_lines(1'b1, 1'b0);
    set_lines(1'b1, 1'b1);
  endtask

  task automatic plain_transfer(input int bits);
    set_lines(1'b1, 1'b0);
    set_lines(1'b0, 1'b0);
    for (int i = 0; i < bits; i++) begin
      set_lines(1'b0, 1'b1);
      set_lines(1'b0, 1'b0);
    end
    set_lines(1'b1, 1'b0);
    set_lines(1'b1, 1'b1);
  endtask

  task automatic load_cases();
    int    fd;
    string line;
    int    f[6];
    case_t c;
    fd = $fopen("dv/i3c_monitor_cases.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the case file dv/i3c_monitor_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
        if ($sscanf(line, "%d %d %d %d %d %d", f[0], f[1], f[2], f[3], f[4], f[5]) == 6) begin
          c = {4'(f[0]), 1'(f[1]), 1'(f[2]), 4'(f[3]), 1'(f[4]), 2'(f[5])};
          cases_q.push_back(c);
        end
      end
    end
    $fclose(fd);
    n_cases = cases_q.size();
    if (n_cases == 0) begin
      fail_run("The case file holds no test cases");
    end
  endtask

  task automatic run_case(input case_t c);
    @(posedge clk);
    hold_ready_low = c.stall;
    @(negedge clk);
    enable   = c.enable;
    hdr_mode = c.hdr_mode;
    if (c.kind != 2'd0) begin
      // A full log drops the new record
      if (c.stall && (exp_q.size() - rx_count >= int'(LOG_DEPTH))) begin
        exp_drops++;
      end else begin
        exp_q.push_back((c.kind == 2'd1) ? i3c_pkg::EVT_HDR_EXIT : i3c_pkg::EVT_TARGET_RESET);
      end
    end
    repeat (4) @(negedge clk);
    case (c.pattern)
      4'd0:    hdr_exit_pattern(int'(c.falls), 0);
      4'd1:    target_reset_pattern(int'(c.falls));
      4'd2:    plain_transfer(int'(c.falls));
      default: hdr_exit_pattern(int'(c.falls), int'(c.falls) / 2);
    endcase
    if (!c.stall) begin
      while (rx_count != exp_q.size()) @(negedge clk);
      // Quiet window so a stray record still shows up
      repeat (24) @(negedge clk);
    end
    check_val("drop_count_o", 32'(drop_count), 32'(exp_drops));
  endtask

  // Ready is low for a random number of cycles between accepts
  initial begin : ready_driver
    int unsigned stall_left;
    stall_left = 0;
    forever begin
      @(negedge clk);
      if (hold_ready_low) begin
        evt_ready = 1'b0;
      end else if (stall_left != 0) begin
        evt_ready = 1'b0;
        stall_left--;
      end else begin
        evt_ready = 1'b1;
        rng_state = next_random(rng_state);
        stall_left = rng_state % 4;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && evt_valid && evt_ready) begin
      if (rx_count >= exp_q.size()) begin
        fail_run($sformatf("Unexpected event record of kind %0d arrived", evt.kind));
      end else begin
        check_val("evt_o.kind", 32'(evt.kind), 32'(exp_q[rx_count]));
        if (rx_count != 0 && evt.ts <= last_ts) begin
          fail_run($sformatf("ERR evt_o.ts: got 0x%0h, expected above 0x%0h", evt.ts, last_ts));
        end
        last_ts  = evt.ts;
        rx_count = rx_count + 1;
      end
    end
  end

  initial begin : watchdog
    wait (n_cases != 0);
    repeat (n_cases * 2000) @(posedge clk);
    fail_run($sformatf("Timeout with %0d of %0d records received", rx_count, exp_q.size()));
  end

  initial begin : main
    rst_n          = 1'b0;
    scl            = 1'b1;
    sda            = 1'b1;
    enable         = 1'b0;
    hdr_mode       = 1'b0;
    evt_ready      = 1'b0;
    hold_ready_low = 1'b1;
    rng_state      = 32'h6106e8d9;
    rx_count       = 0;
    exp_drops      = 0;
    last_ts        = '0;
    n_cases        = 0;
    load_cases();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_val("evt_valid_o", 32'(evt_valid), 32'd0);
    check_val("drop_count_o", 32'(drop_count), 32'd0);
    foreach (cases_q[i]) begin
      run_case(cases_q[i]);
    end
    if (rx_count == exp_q.size()) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      fail_run($sformatf("Only %0d of %0d records were read out", rx_count, exp_q.size()));
    end
  end

endmodule

// File: src/i3c_monitor_top.sv
/*
  I3C monitor top level. Filters the raw pins, derives bus
  conditions, detects patterns and logs them as events
*/
module i3c_monitor_top #(
  parameter int unsigned STABLE_CYCLES = 4,
  parameter int unsigned LOG_DEPTH     = 4
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          scl_i,
  input  logic          sda_i,
  input  logic          enable_i,
  input  logic          is_in_hdr_mode_i,
  output logic          evt_valid_o,
  input  logic          evt_ready_i,
  output i3c_pkg::evt_t evt_o,
  output logic [7:0]    drop_count_o
);

  i3c_pkg::line_state_t scl_state;
  i3c_pkg::line_state_t sda_state;
  i3c_pkg::bus_state_t  bus_state;
  logic                 hdr_exit_detect;
  logic                 target_reset_detect;

  i3c_line_filter #(
    .STABLE_CYCLES (STABLE_CYCLES)
  ) scl_filter_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .line_i  (scl_i),
    .state_o (scl_state)
  );

  i3c_line_filter #(
    .STABLE_CYCLES (STABLE_CYCLES)
  ) sda_filter_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .line_i  (sda_i),
    .state_o (sda_state)
  );

  i3c_bus_conditions i3c_bus_conditions_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_state),
    .sda_i  (sda_state),
    .bus_o  (bus_state)
  );

  i3c_bus_monitor i3c_bus_monitor_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_i              (enable_i),
    .bus_i                 (bus_state),
    .is_in_hdr_mode_i      (is_in_hdr_mode_i),
    .hdr_exit_detect_o     (hdr_exit_detect),
    .target_reset_detect_o (target_reset_detect)
  );

  i3c_event_log #(
    .LOG_DEPTH (LOG_DEPTH)
  ) i3c_event_log_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .hdr_exit_i     (hdr_exit_detect),
    .target_reset_i (target_reset_detect),
    .evt_valid_o    (evt_valid_o),
    .evt_ready_i    (evt_ready_i),
    .evt_o          (evt_o),
    .drop_count_o   (drop_count_o)
  );

endmodule

// File: src/i3c_event_log.sv
/*
  I3C event log. Timestamps detected patterns and queues them
  in a small FIFO read out over valid/ready, counting drops
*/
module i3c_event_log #(
  parameter int unsigned LOG_DEPTH = 4
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          hdr_exit_i,
  input  logic          target_reset_i,
  output logic          evt_valid_o,
  input  logic          evt_ready_i,
  output i3c_pkg::evt_t evt_o,
  output logic [7:0]    drop_count_o
);

  localparam int unsigned PTR_W = (LOG_DEPTH > 1) ? $clog2(LOG_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(LOG_DEPTH + 1);

  logic [i3c_pkg::TS_WIDTH-1:0] ts_q;
  i3c_pkg::evt_t                mem_q [LOG_DEPTH];
  logic [PTR_W-1:0]             wr_ptr_q;
  logic [PTR_W-1:0]             rd_ptr_q;
  logic [CNT_W-1:0]             count_q;
  logic                         valid_q;
  logic [7:0]                   drop_q;
  logic                         any_evt;
  logic                         full;
  logic                         push;
  logic                         pop;
  i3c_pkg::evt_t                wr_evt;
  logic [1:0]                   drop_inc;
  logic [8:0]                   drop_sum;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(LOG_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign any_evt = hdr_exit_i | target_reset_i;
  assign full    = (count_q == CNT_W'(LOG_DEPTH));
  assign push    = any_evt & ~full;
  assign pop     = valid_q & evt_ready_i;

  // Target reset wins when both arrive together
  assign wr_evt.kind = target_reset_i ? i3c_pkg::EVT_TARGET_RESET : i3c_pkg::EVT_HDR_EXIT;
  assign wr_evt.ts   = ts_q;

  assign drop_inc = {1'b0, hdr_exit_i & target_reset_i} + {1'b0, any_evt & full};
  assign drop_sum = {1'b0, drop_q} + {7'b0, drop_inc};

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wr_evt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ts_q     <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      valid_q  <= 1'b0;
      drop_q   <= '0;
    end else begin
      ts_q <= ts_q + 1'b1;
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // An entry is presented one cycle after it was written
      valid_q <= (count_q != '0) && !(pop && count_q == CNT_W'(1));
      drop_q  <= drop_sum[8] ? 8'hff : drop_sum[7:0];
    end
  end

  assign evt_valid_o  = valid_q;
  assign evt_o        = mem_q[rd_ptr_q];
  assign drop_count_o = drop_q;

endmodule

// File: i3c_bus_monitor/i3c_bus_monitor.sv
/*
  I3C bus monitor. Watches for the HDR exit pattern while in
  HDR mode and hosts the Target Reset detector
*/
module i3c_bus_monitor (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  i3c_pkg::bus_state_t bus_i,
  input  logic                is_in_hdr_mode_i,
  output logic                hdr_exit_detect_o,
  output logic                target_reset_detect_o
);

  // One-hot shift register, bit 0 set after four SDA falls
  logic [4:0] exit_shift_q;
  logic       exit_pending_q;
  logic       hdr_exit_q;
  logic       exit_arm;

  // SCL parked low with SDA high starts the exit pattern
  assign exit_arm = enable_i & is_in_hdr_mode_i &
                    bus_i.scl.stable_low & bus_i.sda.stable_high;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_shift_q   <= 5'b10000;
      exit_pending_q <= 1'b0;
      hdr_exit_q     <= 1'b0;
    end else begin
      hdr_exit_q <= enable_i & exit_pending_q & exit_shift_q[0] & bus_i.stop_det;
      if (!enable_i || bus_i.stop_det) begin
        exit_shift_q   <= 5'b10000;
        exit_pending_q <= 1'b0;
      end else if (exit_pending_q) begin
        if (bus_i.sda.neg_edge) begin
          exit_shift_q <= {1'b0, exit_shift_q[4:1]};
        end else if (bus_i.scl.pos_edge && !exit_shift_q[0]) begin
          // SCL pulse in the middle of the pattern, start over
          exit_shift_q <= 5'b10000;
        end
      end else if (exit_arm) begin
        exit_pending_q <= 1'b1;
        exit_shift_q   <= 5'b10000;
      end
    end
  end

  assign hdr_exit_detect_o = hdr_exit_q;

  target_reset_detector target_reset_detector_inst (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .enable_i              (enable_i),
    .bus_i                 (bus_i),
    .target_reset_detect_o (target_reset_detect_o)
  );

endmodule

// File: i3c_bus_monitor/target_reset_detector.sv
/*
  Target Reset detector. Seven SDA falls with SCL low, then a
  repeated START and a STOP, give a one-cycle detect pulse
*/
module target_reset_detector (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  i3c_pkg::bus_state_t bus_i,
  output logic                target_reset_detect_o
);

  logic [2:0] fall_cnt_q;
  logic       sr_seen_q;
  logic       detect_q;
  logic       armed;
  logic       any_start;

  // 14 SDA transitions with SCL low end with seven falls
  assign armed     = (fall_cnt_q == 3'd7);
  assign any_start = bus_i.start_det | bus_i.rstart_det;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fall_cnt_q <= '0;
      sr_seen_q  <= 1'b0;
      detect_q   <= 1'b0;
    end else begin
      detect_q <= enable_i & sr_seen_q & bus_i.stop_det;
      if (!enable_i) begin
        fall_cnt_q <= '0;
        sr_seen_q  <= 1'b0;
      end else if (sr_seen_q) begin
        // STOP completes the pattern, another START breaks it
        if (bus_i.stop_det || any_start) begin
          fall_cnt_q <= '0;
          sr_seen_q  <= 1'b0;
        end
      end else if (armed) begin
        if (any_start) begin
          sr_seen_q <= 1'b1;
        end else if (bus_i.stop_det) begin
          fall_cnt_q <= '0;
        end
      end else if (any_start || bus_i.stop_det) begin
        fall_cnt_q <= '0;
      end else if (bus_i.scl.pos_edge) begin
        // SCL rose before the pattern was complete
        fall_cnt_q <= '0;
      end else if (bus_i.scl.stable_low && bus_i.sda.neg_edge) begin
        fall_cnt_q <= fall_cnt_q + 1'b1;
      end
    end
  end

  assign target_reset_detect_o = detect_q;

endmodule

// File: src/i3c_bus_conditions.sv
/*
  I3C bus conditions. Finds START, repeated START and STOP
  from the filtered lines and tracks bus busy
*/
module i3c_bus_conditions (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  i3c_pkg::line_state_t scl_i,
  input  i3c_pkg::line_state_t sda_i,
  output i3c_pkg::bus_state_t  bus_o
);

  logic busy_q;
  logic sda_fall_scl_high;
  logic start_det;
  logic rstart_det;
  logic stop_det;

  // SDA transitions only count as conditions with SCL settled high
  assign sda_fall_scl_high = sda_i.neg_edge & scl_i.stable_high;

  assign start_det  = sda_fall_scl_high & ~busy_q;
  assign rstart_det = sda_fall_scl_high & busy_q;
  assign stop_det   = sda_i.pos_edge & scl_i.stable_high;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (stop_det) begin
      busy_q <= 1'b0;
    end else if (start_det) begin
      busy_q <= 1'b1;
    end
  end

  assign bus_o.scl        = scl_i;
  assign bus_o.sda        = sda_i;
  assign bus_o.start_det  = start_det;
  assign bus_o.rstart_det = rstart_det;
  assign bus_o.stop_det   = stop_det;
  assign bus_o.busy       = busy_q;

endmodule

// File: src/i3c_line_filter.sv
/*
  I3C line filter. Synchronizes one raw bus line and reports
  its level, single-cycle edges and stability
*/
module i3c_line_filter #(
  parameter int unsigned STABLE_CYCLES = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  line_i,
  output i3c_pkg::line_state_t  state_o
);

  localparam int unsigned RUN_W = $clog2(STABLE_CYCLES + 1);

  logic [1:0]       sync_q;
  logic             level_q;
  logic             pos_edge_q;
  logic             neg_edge_q;
  logic [RUN_W-1:0] run_q;
  logic             change;
  logic             run_done;

  // Synchronized sample differs from the last accepted level
  assign change   = sync_q[1] ^ level_q;
  assign run_done = (run_q == RUN_W'(STABLE_CYCLES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // Lines idle high
      sync_q     <= 2'b11;
      level_q    <= 1'b1;
      pos_edge_q <= 1'b0;
      neg_edge_q <= 1'b0;
    end else begin
      sync_q     <= {sync_q[0], line_i};
      level_q    <= sync_q[1];
      pos_edge_q <= change & sync_q[1];
      neg_edge_q <= change & ~sync_q[1];
    end
  end

  // Run length of equal samples, restarts on every edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q <= '0;
    end else if (change) begin
      run_q <= '0;
    end else if (!run_done) begin
      run_q <= run_q + 1'b1;
    end
  end

  assign state_o.level       = level_q;
  assign state_o.pos_edge    = pos_edge_q;
  assign state_o.neg_edge    = neg_edge_q;
  assign state_o.stable_high = level_q & run_done;
  assign state_o.stable_low  = ~level_q & run_done;

endmodule

// File: common/i3c_pkg.sv
/*
  I3C bus monitor shared types: filtered line state, bus state
  and the event record passed to the event log
*/
package i3c_pkg;

  // Width of the free-running event timestamp
  parameter int unsigned TS_WIDTH = 16;

  // One synchronized and filtered bus line
  typedef struct packed {
    logic level;
    logic pos_edge;
    logic neg_edge;
    logic stable_high;
    logic stable_low;
  } line_state_t;

  // Both lines plus the derived bus conditions
  typedef struct packed {
    line_state_t scl;
    line_state_t sda;
    logic        start_det;
    logic        rstart_det;
    logic        stop_det;
    logic        busy;
  } bus_state_t;

  // Kinds of detected bus patterns
  typedef enum logic [1:0] {
    EVT_HDR_EXIT     = 2'd1,
    EVT_TARGET_RESET = 2'd2
  } evt_kind_e;

  // One entry of the event log
  typedef struct packed {
    evt_kind_e           kind;
    logic [TS_WIDTH-1:0] ts;
  } evt_t;

endpackage
